/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int xlen = 64;
    localparam int word_width = 32;
    localparam int reg_count = 32;

    // Shift amount widths for full-width and word operations.
    localparam int shamt_width = 6;
    localparam int shamt_width_w = 5;

    typedef logic [4:0] reg_addr_t;
    typedef logic [xlen-1:0] xword_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // The same 32-bit word seen as an R-type or an I-type instruction.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } rv_instr_t;

    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_imm = 7'b0010011;
    localparam logic [6:0] op_reg_w = 7'b0111011;
    localparam logic [6:0] op_imm_w = 7'b0011011;
    localparam logic [6:0] op_lui = 7'b0110111;

    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_srl = 3'b101;
    localparam logic [2:0] f3_or = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    // The alternate encoding selects SUB and the arithmetic shifts.
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt = 7'b0100000;
    localparam logic [6:0] f7_mul = 7'b0000001;

    // RV64 shift immediates keep six bits of shamt, so only six funct bits remain.
    localparam logic [5:0] f6_base = 6'b000000;
    localparam logic [5:0] f6_alt = 6'b010000;

endpackage

/* rtl/exec_pkg.sv */
package exec_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [4:0] {
        add,
        sub,
        slt,
        sltu,
        and_op,
        or_op,
        xor_op,
        sll,
        srl,
        sra,
        pass_b,
        addw,
        subw,
        sllw,
        srlw,
        sraw,
        mul
    } alu_op_t;

    typedef struct packed {
        logic      legal;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      use_imm;
        xword_t    imm;
        alu_op_t   op;
    } dec_instr_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        xword_t    data;
    } wb_t;

endpackage

/* rtl/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder
    import rv_isa_pkg::*, exec_pkg::*;
(
    input  rv_instr_t  instr,
    output dec_instr_t dec
);

    r_fmt_t      r;
    i_fmt_t      i;
    logic        base_r;
    logic        alt_r;
    logic [31:0] u_imm;
    xword_t      i_imm;

    assign r = instr.r_fmt;
    assign i = instr.i_fmt;

    assign base_r = (r.funct7 == f7_base);
    assign alt_r = (r.funct7 == f7_alt);

    // The U immediate sits in the upper twenty bits of the R-type view.
    assign u_imm = {r.funct7, r.rs2, r.rs1, r.funct3, 12'b0};
    assign i_imm = {{(xlen-12){i.imm12[11]}}, i.imm12};

    always_comb begin
        dec = '0;
        dec.op = add;
        dec.rd = r.rd;
        dec.rs1 = r.rs1;
        dec.rs2 = r.rs2;

        case (r.opcode)
            op_reg: begin
                if (r.funct7 == f7_mul) begin
                    // Only MUL of the M extension is handled here.
                    dec.legal = (r.funct3 == f3_add);
                    dec.op = mul;
                end else begin
                    case (r.funct3)
                        f3_add: begin
                            dec.legal = base_r || alt_r;
                            dec.op = alt_r ? sub : add;
                        end
                        f3_srl: begin
                            dec.legal = base_r || alt_r;
                            dec.op = alt_r ? sra : srl;
                        end
                        f3_sll: begin
                            dec.legal = base_r;
                            dec.op = sll;
                        end
                        f3_slt: begin
                            dec.legal = base_r;
                            dec.op = slt;
                        end
                        f3_sltu: begin
                            dec.legal = base_r;
                            dec.op = sltu;
                        end
                        f3_xor: begin
                            dec.legal = base_r;
                            dec.op = xor_op;
                        end
                        f3_or: begin
                            dec.legal = base_r;
                            dec.op = or_op;
                        end
                        default: begin
                            dec.legal = base_r;
                            dec.op = and_op;
                        end
                    endcase
                end
            end
            op_imm: begin
                dec.use_imm = 1'b1;
                dec.imm = i_imm;
                dec.legal = 1'b1;
                case (i.funct3)
                    f3_add:  dec.op = add;
                    f3_slt:  dec.op = slt;
                    f3_sltu: dec.op = sltu;
                    f3_xor:  dec.op = xor_op;
                    f3_or:   dec.op = or_op;
                    f3_and:  dec.op = and_op;
                    f3_sll: begin
                        dec.legal = (i.imm12[11:6] == f6_base);
                        dec.op = sll;
                    end
                    default: begin
                        dec.legal = (i.imm12[11:6] == f6_base) || (i.imm12[11:6] == f6_alt);
                        dec.op = (i.imm12[11:6] == f6_alt) ? sra : srl;
                    end
                endcase
            end
            op_reg_w: begin
                case (r.funct3)
                    f3_add: begin
                        dec.legal = base_r || alt_r;
                        dec.op = alt_r ? subw : addw;
                    end
                    f3_sll: begin
                        dec.legal = base_r;
                        dec.op = sllw;
                    end
                    f3_srl: begin
                        dec.legal = base_r || alt_r;
                        dec.op = alt_r ? sraw : srlw;
                    end
                    default: dec.legal = 1'b0;
                endcase
            end
            op_imm_w: begin
                dec.use_imm = 1'b1;
                dec.imm = i_imm;
                case (i.funct3)
                    f3_add: begin
                        dec.legal = 1'b1;
                        dec.op = addw;
                    end
                    f3_sll: begin
                        dec.legal = (i.imm12[11:5] == f7_base);
                        dec.op = sllw;
                    end
                    f3_srl: begin
                        dec.legal = (i.imm12[11:5] == f7_base) || (i.imm12[11:5] == f7_alt);
                        dec.op = (i.imm12[11:5] == f7_alt) ? sraw : srlw;
                    end
                    default: dec.legal = 1'b0;
                endcase
            end
            op_lui: begin
                dec.legal = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm = {{(xlen-32){u_imm[31]}}, u_imm};
                dec.op = pass_b;
            end
            default: dec.legal = 1'b0;
        endcase
    end

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ps

module reg_file
    import rv_isa_pkg::*, exec_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output xword_t    rs1_data,
    output xword_t    rs2_data,
    input  wb_t       wr
);

    xword_t regs [reg_count];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < reg_count; k++) begin
                regs[k] <= '0;
            end
        end else if (wr.valid && wr.rd != '0) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // Register 0 is hardwired to zero.
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu
    import rv_isa_pkg::*, exec_pkg::*;
(
    input  xword_t  operand_a,
    input  xword_t  operand_b,
    input  alu_op_t op,
    output xword_t  result
);

    logic [shamt_width-1:0]   shamt;
    logic [shamt_width_w-1:0] shamt_w;
    logic [word_width-1:0]    a_w;
    logic [word_width-1:0]    sum_w;
    logic [word_width-1:0]    diff_w;
    logic [word_width-1:0]    sll_w;
    logic [word_width-1:0]    srl_w;
    logic [word_width-1:0]    sra_w;
    xword_t                   product;

    function automatic xword_t sext_w(input logic [word_width-1:0] v);
        return {{(xlen-word_width){v[word_width-1]}}, v};
    endfunction

    assign shamt = operand_b[shamt_width-1:0];
    assign shamt_w = operand_b[shamt_width_w-1:0];
    assign a_w = operand_a[word_width-1:0];

    // Word forms work on the low half only, the result is sign-extended below.
    assign sum_w = a_w + operand_b[word_width-1:0];
    assign diff_w = a_w - operand_b[word_width-1:0];
    assign sll_w = a_w << shamt_w;
    assign srl_w = a_w >> shamt_w;
    assign sra_w = $signed(a_w) >>> shamt_w;

    // Only the low 64 bits of the product are kept.
    assign product = operand_a * operand_b;

    always_comb begin
        case (op)
            add:    result = operand_a + operand_b;
            sub:    result = operand_a - operand_b;
            slt:    result = {{(xlen-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
            sltu:   result = {{(xlen-1){1'b0}}, operand_a < operand_b};
            and_op: result = operand_a & operand_b;
            or_op:  result = operand_a | operand_b;
            xor_op: result = operand_a ^ operand_b;
            sll:    result = operand_a << shamt;
            srl:    result = operand_a >> shamt;
            sra:    result = $signed(operand_a) >>> shamt;
            pass_b: result = operand_b;
            addw:   result = sext_w(sum_w);
            subw:   result = sext_w(diff_w);
            sllw:   result = sext_w(sll_w);
            srlw:   result = sext_w(srl_w);
            sraw:   result = sext_w(sra_w);
            mul:    result = product;
            default: result = '0;
        endcase
    end

endmodule

/* rtl/exec_core.sv */
`timescale 1ns/1ps

module exec_core
    import rv_isa_pkg::*, exec_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      instr_valid,
    input  rv_instr_t instr,
    output wb_t       wb
);

    dec_instr_t dec;
    xword_t     rs1_data;
    xword_t     rs2_data;
    xword_t     rs2_value;
    xword_t     operand_a;
    xword_t     operand_b;
    xword_t     result;
    logic       fwd_a;
    logic       fwd_b;

    inst_decoder u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (dec.rs1),
        .rs2_addr (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr       (wb)
    );

    // The result in the write-back register is not in the register file yet.
    assign fwd_a = wb.valid && (wb.rd != '0) && (wb.rd == dec.rs1);
    assign fwd_b = wb.valid && (wb.rd != '0) && (wb.rd == dec.rs2);

    assign operand_a = fwd_a ? wb.data : rs1_data;
    assign rs2_value = fwd_b ? wb.data : rs2_data;
    assign operand_b = dec.use_imm ? dec.imm : rs2_value;

    alu u_alu (
        .operand_a (operand_a),
        .operand_b (operand_b),
        .op        (dec.op),
        .result    (result)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb.valid <= instr_valid && dec.legal && (dec.rd != '0);
            wb.rd <= dec.rd;
            wb.data <= result;
        end
    end

endmodule

/* tb/exec_core_props.sv */
`timescale 1ns/1ps

module exec_core_props
    import rv_isa_pkg::*, exec_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       instr_valid,
    input dec_instr_t dec,
    input wb_t        wb
);

    a_reset_clears_valid: assert property (@(posedge clk) reset |=> !wb.valid)
        else $error("wb.valid set in the cycle after reset");

    a_rd_nonzero: assert property (@(posedge clk) disable iff (reset)
        wb.valid |-> wb.rd != '0)
        else $error("write-back to register 0");

    // An illegal instruction must never write back.
    a_illegal_quiet: assert property (@(posedge clk) disable iff (reset)
        (instr_valid && !dec.legal) |=> !wb.valid)
        else $error("write-back after an illegal instruction");

endmodule

bind exec_core exec_core_props props_i (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .dec         (dec),
    .wb          (wb)
);

/* tb/exec_core_tb.sv */
`timescale 1ns/1ps

module exec_core_tb
    import rv_isa_pkg::*, exec_pkg::*;
;

    localparam int timeout_cycles = 10;

    logic      clk;
    logic      reset;
    logic      instr_valid;
    rv_instr_t instr;
    wb_t       wb;

    xword_t      model [32];
    logic [31:0] lfsr_state = 32'd7;

    exec_core dut_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb          (wb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois LFSR stepped once for every bit that is taken.
    function automatic xword_t rand_bits(input int n);
        xword_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic rv_instr_t r_instr(input logic [6:0] f7, input reg_addr_t rs2,
                                          input reg_addr_t rs1, input logic [2:0] f3,
                                          input reg_addr_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic rv_instr_t i_instr(input logic [11:0] imm, input reg_addr_t rs1,
                                          input logic [2:0] f3, input reg_addr_t rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_instr_t u_instr(input logic [19:0] imm, input reg_addr_t rd);
        return {imm, rd, op_lui};
    endfunction

    // Reference result built from the RV64IM rules and the register model.
    function automatic xword_t ref_result(input rv_instr_t in);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic        is_reg;
        logic        alt;
        logic [31:0] lo;
        xword_t      a;
        xword_t      b;
        opc = in.r_fmt.opcode;
        f3 = in.r_fmt.funct3;
        is_reg = (opc == op_reg) || (opc == op_reg_w);
        alt = in[30];
        if (opc == op_lui) begin
            return {{32{in[31]}}, in[31:12], 12'b0};
        end
        a = model[in.r_fmt.rs1];
        b = is_reg ? model[in.r_fmt.rs2] : {{52{in[31]}}, in[31:20]};
        if (opc == op_reg_w || opc == op_imm_w) begin
            if (f3 == 3'd0) begin
                lo = (is_reg && alt) ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
            end else if (f3 == 3'd1) begin
                lo = a[31:0] << b[4:0];
            end else if (alt) begin
                lo = $signed(a[31:0]) >>> b[4:0];
            end else begin
                lo = a[31:0] >> b[4:0];
            end
            return {{32{lo[31]}}, lo};
        end
        case (f3)
            3'd0: begin
                if (is_reg && in.r_fmt.funct7 == 7'd1) begin
                    return a * b;
                end else if (is_reg && alt) begin
                    return a - b;
                end
                return a + b;
            end
            3'd1: return a << b[5:0];
            3'd2: return {63'b0, $signed(a) < $signed(b)};
            3'd3: return {63'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[5:0];
                end
                return a >> b[5:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp);
        if (got !== exp) begin
            $display("Fail %0t wb: valid got %b exp %b, rd got %0d exp %0d, data got %h exp %h",
                     $time, got.valid, exp.valid, got.rd, exp.rd, got.data, exp.data);
            stop_on_error("write-back does not match the model");
        end
    endtask

    task automatic expect_of(input rv_instr_t in, output wb_t exp);
        exp.valid = 1'b1;
        exp.rd = in.r_fmt.rd;
        exp.data = ref_result(in);
    endtask

    task automatic exec_one(input rv_instr_t in);
        wb_t exp;
        int  n;
        expect_of(in, exp);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr <= in;
        @(posedge clk);
        instr_valid <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb.valid && n < timeout_cycles);
        if (!wb.valid) stop_on_error("no write-back arrived before the timeout");
        if (n != 1) stop_on_error("write-back did not come one cycle after the strobe");
        check_wb(wb, exp);
        model[exp.rd] = exp.data;
    endtask

    // Two strobes on consecutive edges where the second reads the first result.
    task automatic exec_pair(input rv_instr_t first, input rv_instr_t second);
        wb_t exp;
        expect_of(first, exp);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr <= first;
        @(posedge clk);
        instr <= second;
        @(negedge clk);
        check_wb(wb, exp);
        model[exp.rd] = exp.data;
        expect_of(second, exp);
        @(posedge clk);
        instr_valid <= 1'b0;
        @(negedge clk);
        check_wb(wb, exp);
        model[exp.rd] = exp.data;
    endtask

    task automatic check_quiet(input rv_instr_t in);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr <= in;
        @(posedge clk);
        instr_valid <= 1'b0;
        for (int k = 0; k < 3; k++) begin
            @(negedge clk);
            if (wb.valid !== 1'b0) begin
                $display("Fail %0t wb.valid got %b exp 0", $time, wb.valid);
                stop_on_error("unexpected write-back");
            end
        end
    endtask

    task automatic load_registers();
        for (int r = 1; r <= 8; r++) begin
            exec_one(u_instr(20'(rand_bits(20)), 5'(r)));
            exec_one(i_instr(12'(rand_bits(12)), 5'(r), f3_add, 5'(r), op_imm));
        end
        exec_one(i_instr(12'hfff, 0, f3_add, 5, op_imm));
        exec_one(i_instr(12'd1, 0, f3_add, 6, op_imm));
        exec_one(i_instr(12'd33, 0, f3_add, 11, op_imm));
    endtask

    task automatic full_width_ops();
        int sh_list [3] = '{0, 1, 63};
        for (int k = 0; k < 8; k++) begin
            exec_one(r_instr(f7_base, 2, 1, 3'(k), 10, op_reg));
            if (k != 1 && k != 5) exec_one(i_instr(12'(rand_bits(12)), 3, 3'(k), 10, op_imm));
        end
        exec_one(r_instr(f7_alt, 2, 1, f3_add, 10, op_reg));
        exec_one(r_instr(f7_alt, 11, 5, f3_srl, 10, op_reg));
        exec_one(r_instr(f7_base, 6, 5, f3_slt, 10, op_reg));
        exec_one(r_instr(f7_base, 5, 6, f3_slt, 10, op_reg));
        exec_one(r_instr(f7_base, 6, 5, f3_sltu, 10, op_reg));
        exec_one(r_instr(f7_base, 5, 6, f3_sltu, 10, op_reg));
        foreach (sh_list[k]) begin
            exec_one(i_instr({6'b000000, 6'(sh_list[k])}, 1, f3_sll, 10, op_imm));
            exec_one(i_instr({6'b000000, 6'(sh_list[k])}, 5, f3_srl, 10, op_imm));
            exec_one(i_instr({6'b010000, 6'(sh_list[k])}, 5, f3_srl, 10, op_imm));
        end
    endtask

    task automatic word_ops();
        exec_one(r_instr(f7_base, 2, 1, f3_add, 10, op_reg_w));
        exec_one(r_instr(f7_alt, 2, 1, f3_add, 10, op_reg_w));
        // Register 11 holds 33, so only a shift by 1 is expected.
        exec_one(r_instr(f7_base, 11, 1, f3_sll, 12, op_reg_w));
        exec_one(r_instr(f7_base, 11, 5, f3_srl, 12, op_reg_w));
        exec_one(r_instr(f7_alt, 11, 5, f3_srl, 12, op_reg_w));
        exec_one(u_instr(20'h7ffff, 7));
        exec_one(i_instr(12'h7ff, 7, f3_add, 7, op_imm_w));
        exec_one(r_instr(f7_base, 7, 7, f3_add, 8, op_reg_w));
        exec_one(i_instr(12'(rand_bits(12)), 1, f3_add, 10, op_imm_w));
        exec_one(i_instr({7'b0000000, 5'd31}, 1, f3_sll, 10, op_imm_w));
        exec_one(i_instr({7'b0000000, 5'd3}, 5, f3_srl, 10, op_imm_w));
        exec_one(i_instr({7'b0100000, 5'd3}, 5, f3_srl, 10, op_imm_w));
    endtask

    task automatic multiply_ops();
        for (int k = 1; k < 6; k++) begin
            exec_one(r_instr(f7_mul, 5'(k + 1), 5'(k), f3_add, 10, op_reg));
        end
        exec_one(r_instr(f7_mul, 3, 5, f3_add, 10, op_reg));
        exec_one(r_instr(f7_mul, 5, 5, f3_add, 10, op_reg));
    endtask

    task automatic forwarded_pairs();
        exec_pair(i_instr(12'd5, 1, f3_add, 13, op_imm),
                  r_instr(f7_base, 13, 13, f3_add, 14, op_reg));
        exec_pair(r_instr(f7_mul, 2, 3, f3_add, 15, op_reg),
                  r_instr(f7_alt, 15, 1, f3_add, 16, op_reg));
        exec_pair(r_instr(f7_base, 4, 2, f3_xor, 17, op_reg),
                  r_instr(f7_base, 2, 17, f3_add, 18, op_reg_w));
    endtask

    task automatic suppressed_writes();
        check_quiet(r_instr(f7_base, 2, 1, f3_add, 0, op_reg));
        check_quiet(r_instr(f7_base, 2, 1, f3_add, 9, 7'b1111111));
        exec_one(r_instr(f7_base, 0, 0, f3_add, 15, op_reg));
        exec_one(r_instr(f7_base, 1, 0, f3_add, 15, op_reg));
    endtask

    initial begin
        foreach (model[k]) model[k] = '0;
        reset = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        load_registers();
        full_width_ops();
        word_ops();
        multiply_ops();
        forwarded_pairs();
        suppressed_writes();
        repeat (2) @(posedge clk);
        $display("sim passed");
        $finish;
    end

endmodule

/* sources.f */
rtl/rv_isa_pkg.sv
rtl/exec_pkg.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/exec_core.sv
tb/exec_core_props.sv
tb/exec_core_tb.sv

/* Makefile */
TOP := exec_core_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -qx "sim passed"

clean:
	rm -rf obj_dir
